/* src/pe_fmt_pkg.sv */
`default_nettype none

// Number formats of the two operands and the partial sum
package pe_fmt_pkg;

  // Left operand, arrives on the l stream
  parameter int OP0_WIDTH = 16;

  // Top operand, arrives on the t stream
  parameter int OP1_WIDTH = 16;

  // Signedness of each operand
  // 0 means two's complement, 1 means plain binary
  parameter int OP0_UNSIGNED = 0;
  parameter int OP1_UNSIGNED = 0;

  // Headroom above the full product width
  // 4 bits cover up to 16 accumulated products
  parameter int GUARD_BITS = 4;

endpackage : pe_fmt_pkg

`default_nettype wire

/* src/pe_stream_pkg.sv */
`default_nettype none

// Conventions of the valid/ready streams inside the node
package pe_stream_pkg;

  // Holding slots per input skid buffer
  // Two slots keep full rate with a registered ready
  parameter int SKID_SLOTS = 2;

  // Width of the read and write slot pointers
  parameter int SLOT_IDX_W = 1;

endpackage : pe_stream_pkg

`default_nettype wire

/* src/axis_skid_buffer.sv */
`default_nettype none

// Registered skid buffer for one operand stream
// Ready on the input side comes from a flop, never from m_ready
module axis_skid_buffer #(
  parameter int W = 16
) (
  input  logic         clk,
  input  logic         rst_n,
  // Upstream side
  input  logic [W-1:0] s_data,
  input  logic         s_valid,
  input  logic         s_last,
  output logic         s_ready,
  // Downstream side
  output logic [W-1:0] m_data,
  output logic         m_valid,
  output logic         m_last,
  input  logic         m_ready
);
  import pe_stream_pkg::*;

  // Slot storage, word plus its last mark
  logic [W-1:0]          slot_data [SKID_SLOTS];
  logic                  slot_last [SKID_SLOTS];

  logic [SLOT_IDX_W-1:0] wr_ptr;
  logic [SLOT_IDX_W-1:0] rd_ptr;
  logic [SLOT_IDX_W:0]   count;
  logic [SLOT_IDX_W:0]   count_next;
  logic                  push;
  logic                  pop;

  assign push = s_valid & s_ready;
  assign pop  = m_valid & m_ready;

  // Occupancy after this edge
  always_comb begin
    case ({push, pop})
      2'b10:   count_next = count + 1'b1;
      2'b01:   count_next = count - 1'b1;
      default: count_next = count;
    endcase
  end

  // Pointers, occupancy and registered ready
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      s_ready <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == SLOT_IDX_W'(SKID_SLOTS - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == SLOT_IDX_W'(SKID_SLOTS - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count_next;
      // Drop ready only once every slot is taken
      s_ready <= (count_next != (SLOT_IDX_W + 1)'(SKID_SLOTS));
    end
  end

  // Slot write, payload only
  always_ff @(posedge clk) begin
    if (push) begin
      slot_data[wr_ptr] <= s_data;
      slot_last[wr_ptr] <= s_last;
    end
  end

  // Oldest word on the output
  assign m_valid = (count != '0);
  assign m_data  = slot_data[rd_ptr];
  assign m_last  = slot_last[rd_ptr];

endmodule : axis_skid_buffer

`default_nettype wire

/* src/mac_datapath.sv */
`default_nettype none

// Multiply-accumulate datapath with a one-word result register
module mac_datapath #(
  parameter int OP0_W   = pe_fmt_pkg::OP0_WIDTH,
  parameter int OP1_W   = pe_fmt_pkg::OP1_WIDTH,
  parameter int OP0_UNS = pe_fmt_pkg::OP0_UNSIGNED,
  parameter int OP1_UNS = pe_fmt_pkg::OP1_UNSIGNED,
  parameter int PSUM_W  = pe_fmt_pkg::OP0_WIDTH + pe_fmt_pkg::OP1_WIDTH
                          + pe_fmt_pkg::GUARD_BITS
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [OP0_W-1:0]  op0,
  input  logic [OP1_W-1:0]  op1,
  input  logic              take,
  input  logic              first,
  input  logic              finish,
  input  logic              d_ready,
  output logic [PSUM_W-1:0] d_data,
  output logic              d_valid,
  output logic              d_last,
  output logic              result_busy
);
  // One extra bit per operand so both flavours multiply as signed
  localparam int PROD_W = OP0_W + OP1_W + 2;

  logic signed [OP0_W:0]      op0_ext;
  logic signed [OP1_W:0]      op1_ext;
  logic signed [PROD_W-1:0]   product;
  logic signed [PSUM_W-1:0]   product_w;
  logic signed [PSUM_W-1:0]   sum_base;
  logic signed [PSUM_W-1:0]   sum_next;
  logic signed [PSUM_W-1:0]   acc;

  // Zero bit for unsigned, sign bit otherwise
  assign op0_ext = (OP0_UNS != 0) ? {1'b0, op0} : {op0[OP0_W-1], op0};
  assign op1_ext = (OP1_UNS != 0) ? {1'b0, op1} : {op1[OP1_W-1], op1};

  assign product   = op0_ext * op1_ext;
  assign product_w = PSUM_W'(product);

  // First pair of a vector starts from zero
  assign sum_base = first ? '0 : acc;
  assign sum_next = sum_base + product_w;

  // Running sum and result word
  always_ff @(posedge clk) begin
    if (take) begin
      acc <= sum_next;
    end
    if (finish) begin
      d_data <= sum_next;
    end
  end

  // Result handshake
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      d_valid <= 1'b0;
    end else if (finish) begin
      // Control only finishes into a free or draining register
      d_valid <= 1'b1;
    end else if (d_ready) begin
      d_valid <= 1'b0;
    end
  end

  // Each result is a one-word packet
  assign d_last      = 1'b1;
  assign result_busy = d_valid;

endmodule : mac_datapath

`default_nettype wire

/* src/pe_control.sv */
`default_nettype none

// Pair join, forwarding and end-of-vector control
module pe_control (
  input  logic clk,
  input  logic rst_n,
  // Buffered operand streams
  input  logic l_valid,
  input  logic l_last,
  input  logic t_valid,
  input  logic t_last,
  output logic l_ready,
  output logic t_ready,
  // Forwarded streams
  output logic r_valid,
  input  logic r_ready,
  output logic b_valid,
  input  logic b_ready,
  // Datapath strobes
  output logic take,
  output logic first,
  output logic finish,
  input  logic result_busy,
  input  logic d_ready,
  // Status
  output logic err_unaligned
);
  logic join_ok;
  logic res_ok;
  logic pair;
  logic start_flag;
  logic last_mismatch;

  // Both operands present
  assign join_ok = l_valid & t_valid;

  // Only the closing pair needs room in the result register
  // A result leaving on this edge counts as room
  assign res_ok = ~l_last | ~result_busy | d_ready;

  // Pair consumed on this edge
  assign pair = join_ok & res_ok & r_ready & b_ready;

  // Pop both buffers together
  assign l_ready = pair;
  assign t_ready = pair;

  // Forward valids leave out their own ready
  // so r and b transfers still land exactly on pair
  assign r_valid = join_ok & res_ok & b_ready;
  assign b_valid = join_ok & res_ok & r_ready;

  // Datapath strobes
  assign take   = pair;
  assign first  = start_flag;
  // Left tlast closes the vector
  assign finish = pair & l_last;

  assign last_mismatch = l_last ^ t_last;

  // Start-of-vector marker
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      start_flag <= 1'b1;
    end else if (finish) begin
      start_flag <= 1'b1;
    end else if (take) begin
      start_flag <= 1'b0;
    end
  end

  // One pulse per misaligned pair
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      err_unaligned <= 1'b0;
    end else begin
      err_unaligned <= pair & last_mismatch;
    end
  end

endmodule : pe_control

`default_nettype wire

/* src/systolic_pe.sv */
`default_nettype none

// One node of a systolic matrix-multiply array
// First row of its column, so there is no partial-sum input
module systolic_pe #(
  parameter  int OP0_W   = pe_fmt_pkg::OP0_WIDTH,
  parameter  int OP1_W   = pe_fmt_pkg::OP1_WIDTH,
  parameter  int OP0_UNS = pe_fmt_pkg::OP0_UNSIGNED,
  parameter  int OP1_UNS = pe_fmt_pkg::OP1_UNSIGNED,
  // Full product plus guard bits
  localparam int PSUM_W  = OP0_W + OP1_W + pe_fmt_pkg::GUARD_BITS
) (
  input  logic              clk,
  input  logic              rst_n,
  // Left input
  input  logic [OP0_W-1:0]  l_data,
  input  logic              l_valid,
  input  logic              l_last,
  output logic              l_ready,
  // Top input
  input  logic [OP1_W-1:0]  t_data,
  input  logic              t_valid,
  input  logic              t_last,
  output logic              t_ready,
  // Right output
  output logic [OP0_W-1:0]  r_data,
  output logic              r_valid,
  output logic              r_last,
  input  logic              r_ready,
  // Bottom output
  output logic [OP1_W-1:0]  b_data,
  output logic              b_valid,
  output logic              b_last,
  input  logic              b_ready,
  // Down output, finished dot products
  output logic [PSUM_W-1:0] d_data,
  output logic              d_valid,
  output logic              d_last,
  input  logic              d_ready,
  output logic              err_unaligned
);
  // Buffered left stream
  logic [OP0_W-1:0] lb_data;
  logic             lb_valid;
  logic             lb_last;
  logic             lb_ready;

  // Buffered top stream
  logic [OP1_W-1:0] tb_data;
  logic             tb_valid;
  logic             tb_last;
  logic             tb_ready;

  // Control to datapath
  logic             take;
  logic             first;
  logic             finish;
  logic             result_busy;

  axis_skid_buffer #(
    .W(OP0_W)
  ) l_buf (
    .clk     (clk),
    .rst_n   (rst_n),
    .s_data  (l_data),
    .s_valid (l_valid),
    .s_last  (l_last),
    .s_ready (l_ready),
    .m_data  (lb_data),
    .m_valid (lb_valid),
    .m_last  (lb_last),
    .m_ready (lb_ready)
  );

  axis_skid_buffer #(
    .W(OP1_W)
  ) t_buf (
    .clk     (clk),
    .rst_n   (rst_n),
    .s_data  (t_data),
    .s_valid (t_valid),
    .s_last  (t_last),
    .s_ready (t_ready),
    .m_data  (tb_data),
    .m_valid (tb_valid),
    .m_last  (tb_last),
    .m_ready (tb_ready)
  );

  pe_control i_control (
    .clk           (clk),
    .rst_n         (rst_n),
    .l_valid       (lb_valid),
    .l_last        (lb_last),
    .t_valid       (tb_valid),
    .t_last        (tb_last),
    .l_ready       (lb_ready),
    .t_ready       (tb_ready),
    .r_valid       (r_valid),
    .r_ready       (r_ready),
    .b_valid       (b_valid),
    .b_ready       (b_ready),
    .take          (take),
    .first         (first),
    .finish        (finish),
    .result_busy   (result_busy),
    .d_ready       (d_ready),
    .err_unaligned (err_unaligned)
  );

  mac_datapath #(
    .OP0_W   (OP0_W),
    .OP1_W   (OP1_W),
    .OP0_UNS (OP0_UNS),
    .OP1_UNS (OP1_UNS),
    .PSUM_W  (PSUM_W)
  ) i_datapath (
    .clk         (clk),
    .rst_n       (rst_n),
    .op0         (lb_data),
    .op1         (tb_data),
    .take        (take),
    .first       (first),
    .finish      (finish),
    .d_ready     (d_ready),
    .d_data      (d_data),
    .d_valid     (d_valid),
    .d_last      (d_last),
    .result_busy (result_busy)
  );

  // Operands pass on unchanged with their tlast
  assign r_data = lb_data;
  assign r_last = lb_last;
  assign b_data = tb_data;
  assign b_last = tb_last;

endmodule : systolic_pe

`default_nettype wire

/* dv/systolic_pe_tb.sv */
`default_nettype none

module systolic_pe_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import pe_fmt_pkg::*;

  localparam int OP0_W   = OP0_WIDTH;
  localparam int OP1_W   = OP1_WIDTH;
  localparam int PSUM_W  = OP0_W + OP1_W + GUARD_BITS;
  localparam int N_ENT   = 7;
  localparam int MAX_LEN = 16;

  logic              clk;
  logic              rst_n;
  logic [OP0_W-1:0]  l_data;
  logic              l_valid;
  logic              l_last;
  logic              l_ready;
  logic [OP0_W-1:0]  r_data;
  logic              r_valid;
  logic              r_last;
  logic              r_ready;
  logic [OP1_W-1:0]  t_data;
  logic              t_valid;
  logic              t_last;
  logic              t_ready;
  logic [OP1_W-1:0]  b_data;
  logic              b_valid;
  logic              b_last;
  logic              b_ready;
  logic [PSUM_W-1:0] d_data;
  logic              d_valid;
  logic              d_last;
  logic              d_ready;
  logic              err_unaligned;

  // Stimulus table with one row per vector
  string  ent_name [N_ENT];
  int     ent_len  [N_ENT];
  // Element whose top tlast is inverted or -1 for none
  int     ent_flip [N_ENT];
  // Sum of signed products worked out by hand
  longint ent_sum  [N_ENT];
  int     l_word   [N_ENT][MAX_LEN];
  int     t_word   [N_ENT][MAX_LEN];
  int     pend_l[$];
  int     pend_t[$];
  int     n_loaded = 0;

  logic [15:0]       lfsr = 16'd20819;
  logic              go = 1'b0;
  logic              exp_err = 1'b0;
  logic              d_hold = 1'b0;
  logic [PSUM_W-1:0] held_sum = '0;
  int                pair_ent = 0;
  int                pair_el = 0;
  int                pairs_seen = 0;
  int                res_idx = 0;

  systolic_pe i_systolic_pe (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // 16-bit Fibonacci LFSR with taps 16 14 13 11
  function automatic logic rand_bit();
    logic fb;
    fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  task automatic stop_run(input string why);
    $display("TEST FAILED");
    $fatal(1, "%s", why);
  endtask

  task automatic check_psum(input string name, input logic signed [PSUM_W-1:0] expected,
                            input logic signed [PSUM_W-1:0] actual);
    if (actual !== expected) begin
      $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
      stop_run("mismatch on the d stream");
    end
  endtask

  task automatic check_operand(input string name, input logic signed [OP0_W-1:0] expected,
                               input logic signed [OP0_W-1:0] actual);
    if (actual !== expected) begin
      $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
      stop_run("mismatch on a forwarded operand");
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("ERROR %s: expected %0b, actual %0b", name, expected, actual);
      stop_run("mismatch on a control flag");
    end
  endtask

  // Copies the pending word queues into the next table row
  task automatic add_entry(input string name, input int flip, input longint sum);
    int i;
    ent_name[n_loaded] = name;
    ent_len[n_loaded]  = pend_l.size();
    ent_flip[n_loaded] = flip;
    ent_sum[n_loaded]  = sum;
    for (i = 0; i < pend_l.size(); i++) begin
      l_word[n_loaded][i] = pend_l[i];
      t_word[n_loaded][i] = pend_t[i];
    end
    n_loaded++;
  endtask

  task automatic feed_left();
    int e;
    int i;
    for (e = 0; e < N_ENT; e++) begin
      for (i = 0; i < ent_len[e]; i++) begin
        // Random idle cycles before each word
        while (rand_bit()) begin
          l_valid <= 1'b0;
          @(posedge clk);
        end
        l_data  <= OP0_W'(l_word[e][i]);
        l_last  <= (i == ent_len[e] - 1);
        l_valid <= 1'b1;
        // Registered ready seen mid cycle decides the next edge
        @(negedge clk);
        while (!l_ready) @(negedge clk);
        @(posedge clk);
      end
    end
    l_valid <= 1'b0;
  endtask

  task automatic feed_top();
    int e;
    int i;
    for (e = 0; e < N_ENT; e++) begin
      for (i = 0; i < ent_len[e]; i++) begin
        while (rand_bit()) begin
          t_valid <= 1'b0;
          @(posedge clk);
        end
        t_data  <= OP1_W'(t_word[e][i]);
        // Flipped tlast makes one misaligned pair
        t_last  <= (i == ent_len[e] - 1) ^ (i == ent_flip[e]);
        t_valid <= 1'b1;
        @(negedge clk);
        while (!t_ready) @(negedge clk);
        @(posedge clk);
      end
    end
    t_valid <= 1'b0;
  endtask

  initial begin
    l_valid = 1'b0;
    l_data  = '0;
    l_last  = 1'b0;
    wait (go);
    @(posedge clk);
    feed_left();
  end

  initial begin
    t_valid = 1'b0;
    t_data  = '0;
    t_last  = 1'b0;
    wait (go);
    @(posedge clk);
    feed_top();
  end

  // Forward readies high from the start and mostly high once traffic runs
  initial begin
    r_ready = 1'b1;
    b_ready = 1'b1;
    wait (go);
    forever begin
      @(posedge clk);
      r_ready <= rand_bit() | rand_bit();
      b_ready <= rand_bit() | rand_bit();
    end
  end

  // d_ready low across the first two vector ends
  initial begin
    d_ready = 1'b0;
    wait (go);
    wait (pairs_seen == ent_len[0] + ent_len[1] - 1);
    repeat (10) @(negedge clk);
    check_flag("first result waiting", 1'b1, d_valid);
    check_flag("second last pair stalled", 1'b1, pairs_seen == ent_len[0] + ent_len[1] - 1);
    forever begin
      @(posedge clk);
      d_ready <= rand_bit();
    end
  end

  always @(negedge clk) begin : monitor
    logic r_xfer;
    logic b_xfer;
    if (go) begin
      // One-cycle pulse after a misaligned pair and low otherwise
      check_flag("err_unaligned", exp_err, err_unaligned);
      r_xfer  = r_valid & r_ready;
      b_xfer  = b_valid & b_ready;
      exp_err = 1'b0;
      check_flag("r and b on the same edge", r_xfer, b_xfer);
      if (r_xfer && pair_ent >= N_ENT) begin
        stop_run("a word left on r and b after the last table entry");
      end else if (r_xfer) begin
        check_operand({ent_name[pair_ent], " r_data"}, OP0_W'(l_word[pair_ent][pair_el]), r_data);
        check_flag({ent_name[pair_ent], " r_last"}, pair_el == ent_len[pair_ent] - 1, r_last);
        check_operand({ent_name[pair_ent], " b_data"}, OP1_W'(t_word[pair_ent][pair_el]), b_data);
        check_flag({ent_name[pair_ent], " b_last"},
                   (pair_el == ent_len[pair_ent] - 1) ^ (pair_el == ent_flip[pair_ent]), b_last);
        exp_err = (pair_el == ent_flip[pair_ent]);
        pairs_seen++;
        pair_el++;
        if (pair_el == ent_len[pair_ent]) begin
          pair_el = 0;
          pair_ent++;
        end
      end
      // A waiting result keeps its value
      if (d_hold) begin
        check_flag("d_valid held", 1'b1, d_valid);
        check_psum("d_data held", held_sum, d_data);
      end
      if (d_valid && d_ready && res_idx >= N_ENT) begin
        stop_run("a result left on d after the last table entry");
      end else if (d_valid && d_ready) begin
        check_psum(ent_name[res_idx], PSUM_W'(ent_sum[res_idx]), d_data);
        check_flag({ent_name[res_idx], " d_last"}, 1'b1, d_last);
        res_idx++;
      end
      d_hold   = d_valid & ~d_ready;
      held_sum = d_data;
    end
  end

  initial begin : watchdog
    int e;
    int total;
    total = 0;
    wait (go);
    for (e = 0; e < N_ENT; e++) begin
      total += ent_len[e];
    end
    repeat (40 * total) @(posedge clk);
    stop_run("timeout: results did not arrive");
  end

  initial begin
    rst_n = 1'b0;
    pend_l = '{1, 2, 3};
    pend_t = '{4, 5, 6};
    add_entry("basic", -1, 64'sd32);
    pend_l = '{-3, 7, -100, 250};
    pend_t = '{5, -2, -40, 4};
    add_entry("negative", -1, 64'sd4971);
    pend_l.delete();
    pend_t.delete();
    repeat (MAX_LEN) begin
      pend_l.push_back(-32768);
      pend_t.push_back(-32768);
    end
    // 16 times 2**30 needs the guard bits
    add_entry("extreme", -1, 64'sd17179869184);
    pend_l = '{32767, -32768};
    pend_t = '{-32768, -32768};
    add_entry("mixed_extreme", -1, 64'sd32768);
    pend_l = '{-7};
    pend_t = '{9};
    add_entry("single", -1, -64'sd63);
    // Top tlast missing on the closing pair
    pend_l = '{10, 20, 30};
    pend_t = '{1, 2, 3};
    add_entry("late_top_last", 2, 64'sd140);
    // Extra top tlast mid vector
    pend_l = '{-5, 6, -7, 8};
    pend_t = '{3, -4, 5, 100};
    add_entry("early_top_last", 1, 64'sd726);
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    // Quiet outputs before any input
    repeat (3) begin
      @(negedge clk);
      check_flag("r_valid after reset", 1'b0, r_valid);
      check_flag("b_valid after reset", 1'b0, b_valid);
      check_flag("d_valid after reset", 1'b0, d_valid);
      check_flag("err_unaligned after reset", 1'b0, err_unaligned);
    end
    go = 1'b1;
    wait (res_idx == N_ENT);
    repeat (4) @(negedge clk);
    if (pair_ent != N_ENT) begin
      stop_run("not every pair reached the r and b outputs");
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* systolic_pe.f */
src/pe_fmt_pkg.sv
src/pe_stream_pkg.sv
src/axis_skid_buffer.sv
src/mac_datapath.sv
src/pe_control.sv
src/systolic_pe.sv
dv/systolic_pe_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator and run it, the exit status is the test result
cd "$(dirname "$0")" &&
  verilator --binary --timing --top-module systolic_pe_tb -f systolic_pe.f \
    -o systolic_pe_sim &&
  ./obj_dir/systolic_pe_sim ||
  { echo "systolic_pe simulation failed" >&2; exit 1; }
